/* beat_spill_reg.sv */
`timescale 1ns/1ns

module beat_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Entry A takes new beats, entry B catches a stalled one
  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign a_fill  = valid_i && ready_o;
  // A empties whenever B is free, either downstream or into B
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B always holds the older beat
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = !a_full_q || !b_full_q;

endmodule

/* mcast_patterns.txt */
// addr mask data id inject_mask expected_sel expected_resp, all hex
// Response codes 0 OKAY, 2 SLVERR, 3 DECERR
00000010 00000000 11110000 1 0 1 0
0001abcc 00000000 22220001 2 0 2 0
00020004 00000000 33330002 3 0 4 0
0003fffc 00000000 44440003 4 0 8 0
00001234 00030000 55550004 5 0 f 0
00010040 000200f0 66660005 6 0 a 0
00000100 00010000 77770006 7 c 3 0
00020000 0001ffff 88880007 8 0 c 0
00040000 00040000 99990008 9 0 1 0
00100000 00000000 aaaa0009 a 0 0 3
00100000 00030000 bbbb000a b f 0 3
00000000 000000ff cccc000b c 0 1 0
ffff0000 ffff0000 dddd000c d 0 f 0
00005678 00030000 eeee000d e 4 f 2
00011110 00020000 ffff000e f 8 a 2
0001a000 00000000 0123000f 0 2 2 2

/* mcast_pkg.sv */
package mcast_pkg;

  // ----------------------------------------
  // Widths and port count
  // ----------------------------------------

  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ID_WIDTH   = 4;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ID_WIDTH-1:0]   id_t;

  // One bit per target port
  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // ----------------------------------------
  // Response codes
  // ----------------------------------------

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  // ----------------------------------------
  // Region table
  // ----------------------------------------

  // All regions share one size, naturally aligned
  localparam addr_t PORT_SPAN = 32'h0001_0000;

  // Port i starts at i * PORT_SPAN
  localparam addr_t [NUM_PORTS-1:0] PORT_BASE = {
    32'h0003_0000,
    32'h0002_0000,
    32'h0001_0000,
    32'h0000_0000
  };

  // Offset bits inside a region
  localparam int unsigned REGION_BITS = $clog2(PORT_SPAN);

  // Selects the offset part of an address
  localparam addr_t REGION_LO_MASK = addr_t'((64'd1 << REGION_BITS) - 64'd1);

  // ----------------------------------------
  // Payload types
  // ----------------------------------------

  // Request beat held by the input cut, 100 bits
  typedef struct packed {
    addr_t addr;
    addr_t mask;
    data_t data;
    id_t   id;
  } req_beat_t;

  // Response beat held by the output cut, 6 bits
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } rsp_beat_t;

endpackage

/* mcast_port_slot.sv */
`timescale 1ns/1ns

module mcast_port_slot #(
  parameter int unsigned PORT_IDX = 0
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            launch_i,
  input  mcast_pkg::addr_t req_addr_i,
  input  mcast_pkg::addr_t req_mask_i,
  input  mcast_pkg::data_t req_data_i,
  output logic            hit_o,
  output logic            mst_req_valid_o,
  output mcast_pkg::addr_t mst_addr_o,
  output mcast_pkg::addr_t mst_mask_o,
  output mcast_pkg::data_t mst_data_o,
  output logic            mst_is_mcast_o,
  input  logic            mst_req_ready_i
);

  import mcast_pkg::*;

  // ----------------------------------------
  // Region match
  // ----------------------------------------

  // Upper address bits that differ from this port's base
  addr_t base_diff;
  // Differences that the multicast mask does not cover
  addr_t fixed_diff;

  assign base_diff  = (req_addr_i ^ PORT_BASE[PORT_IDX]) & ~REGION_LO_MASK;
  // A zero mask leaves the plain unicast compare
  assign fixed_diff = base_diff & ~req_mask_i;
  assign hit_o      = (fixed_diff == '0);

  // ----------------------------------------
  // Forwarded request hold
  // ----------------------------------------

  logic  valid_q;
  addr_t addr_q;
  addr_t mask_q;
  data_t data_q;
  logic  mcast_q;

  logic  take;

  assign take = launch_i && hit_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (mst_req_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Copy rewritten into this port's region
  always_ff @(posedge clk_i) begin
    if (take) begin
      addr_q  <= PORT_BASE[PORT_IDX] | (req_addr_i & REGION_LO_MASK);
      mask_q  <= req_mask_i & REGION_LO_MASK;
      data_q  <= req_data_i;
      mcast_q <= (req_mask_i != '0);
    end
  end

  assign mst_req_valid_o = valid_q;
  assign mst_addr_o      = addr_q;
  assign mst_mask_o      = mask_q;
  assign mst_data_o      = data_q;
  assign mst_is_mcast_o  = mcast_q;

endmodule

/* mcast_rsp_join.sv */
`timescale 1ns/1ns

module mcast_rsp_join (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         cut_valid_i,
  input  mcast_pkg::id_t                               cut_id_i,
  input  mcast_pkg::port_mask_t                        hit_i,
  input  mcast_pkg::port_mask_t                        mst_rsp_valid_i,
  input  mcast_pkg::resp_t [mcast_pkg::NUM_PORTS-1:0] mst_rsp_resp_i,
  output logic                                         launch_o,
  output mcast_pkg::port_mask_t                        mst_rsp_ready_o,
  output logic                                         rsp_valid_o,
  output mcast_pkg::id_t                               rsp_id_o,
  output mcast_pkg::resp_t                             rsp_resp_o,
  input  logic                                         rsp_ready_i
);

  import mcast_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COLLECT,
    ST_RESPOND
  } state_e;

  state_e     state_q;
  state_e     state_d;
  port_mask_t pending_q;
  port_mask_t pending_d;
  logic       err_q;
  logic       err_d;
  logic       no_hit_q;
  logic       no_hit_d;
  id_t        id_q;

  port_mask_t rsp_take;
  logic       slverr_seen;

  // One transaction at a time
  assign launch_o        = (state_q == ST_IDLE) && cut_valid_i;
  assign mst_rsp_ready_o = (state_q == ST_COLLECT) ? pending_q : '0;
  assign rsp_take        = mst_rsp_valid_i & mst_rsp_ready_o;

  always_comb begin
    slverr_seen = 1'b0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      if (rsp_take[p] && (mst_rsp_resp_i[p] == RESP_SLVERR)) begin
        slverr_seen = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Transaction FSM
  // ----------------------------------------

  always_comb begin
    state_d   = state_q;
    pending_d = pending_q;
    err_d     = err_q;
    no_hit_d  = no_hit_q;
    case (state_q)
      ST_IDLE: begin
        if (launch_o) begin
          pending_d = hit_i;
          err_d     = 1'b0;
          no_hit_d  = (hit_i == '0);
          // Unmatched request is answered locally
          state_d   = (hit_i == '0) ? ST_RESPOND : ST_COLLECT;
        end
      end
      ST_COLLECT: begin
        pending_d = pending_q & ~rsp_take;
        err_d     = err_q | slverr_seen;
        if (pending_d == '0) begin
          state_d = ST_RESPOND;
        end
      end
      ST_RESPOND: begin
        if (rsp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      pending_q <= '0;
      err_q     <= 1'b0;
      no_hit_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
      err_q     <= err_d;
      no_hit_q  <= no_hit_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch_o) begin
      id_q <= cut_id_i;
    end
  end

  // Merged response, DECERR wins over SLVERR
  assign rsp_valid_o = (state_q == ST_RESPOND);
  assign rsp_id_o    = id_q;
  assign rsp_resp_o  = no_hit_q ? RESP_DECERR : (err_q ? RESP_SLVERR : RESP_OKAY);

endmodule

/* mcast_write_demux.sv */
`timescale 1ns/1ns

module mcast_write_demux (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  // Initiator request
  input  logic                                         slv_req_valid_i,
  output logic                                         slv_req_ready_o,
  input  mcast_pkg::addr_t                             slv_req_addr_i,
  input  mcast_pkg::addr_t                             slv_req_mask_i,
  input  mcast_pkg::data_t                             slv_req_data_i,
  input  mcast_pkg::id_t                               slv_req_id_i,
  // Initiator response
  output logic                                         slv_rsp_valid_o,
  input  logic                                         slv_rsp_ready_i,
  output mcast_pkg::id_t                               slv_rsp_id_o,
  output mcast_pkg::resp_t                             slv_rsp_resp_o,
  // Target requests
  output mcast_pkg::port_mask_t                        mst_req_valid_o,
  input  mcast_pkg::port_mask_t                        mst_req_ready_i,
  output mcast_pkg::addr_t [mcast_pkg::NUM_PORTS-1:0] mst_req_addr_o,
  output mcast_pkg::addr_t [mcast_pkg::NUM_PORTS-1:0] mst_req_mask_o,
  output mcast_pkg::data_t [mcast_pkg::NUM_PORTS-1:0] mst_req_data_o,
  output mcast_pkg::port_mask_t                        mst_req_is_mcast_o,
  // Target responses
  input  mcast_pkg::port_mask_t                        mst_rsp_valid_i,
  output mcast_pkg::port_mask_t                        mst_rsp_ready_o,
  input  mcast_pkg::resp_t [mcast_pkg::NUM_PORTS-1:0] mst_rsp_resp_i
);

  import mcast_pkg::*;

  // ----------------------------------------
  // Request cut
  // ----------------------------------------

  req_beat_t  req_cut;
  logic       req_cut_valid;
  logic       launch;

  beat_spill_reg #(
    .T ( req_beat_t )
  ) i_req_cut (
    .clk_i,
    .rst_i,
    .valid_i ( slv_req_valid_i                                                   ),
    .ready_o ( slv_req_ready_o                                                   ),
    .data_i  ( {slv_req_addr_i, slv_req_mask_i, slv_req_data_i, slv_req_id_i} ),
    .valid_o ( req_cut_valid                                                     ),
    .ready_i ( launch                                                            ),
    .data_o  ( req_cut                                                           )
  );

  // ----------------------------------------
  // Port slots
  // ----------------------------------------

  port_mask_t slot_hit;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
    mcast_port_slot #(
      .PORT_IDX ( i )
    ) i_slot (
      .clk_i,
      .rst_i,
      .launch_i        ( launch                ),
      .req_addr_i      ( req_cut.addr          ),
      .req_mask_i      ( req_cut.mask          ),
      .req_data_i      ( req_cut.data          ),
      .hit_o           ( slot_hit[i]           ),
      .mst_req_valid_o ( mst_req_valid_o[i]    ),
      .mst_addr_o      ( mst_req_addr_o[i]     ),
      .mst_mask_o      ( mst_req_mask_o[i]     ),
      .mst_data_o      ( mst_req_data_o[i]     ),
      .mst_is_mcast_o  ( mst_req_is_mcast_o[i] ),
      .mst_req_ready_i ( mst_req_ready_i[i]    )
    );
  end

  // ----------------------------------------
  // Response join and cut
  // ----------------------------------------

  logic      join_rsp_valid;
  logic      join_rsp_ready;
  id_t       join_rsp_id;
  resp_t     join_rsp_resp;
  rsp_beat_t rsp_out;

  mcast_rsp_join i_join (
    .clk_i,
    .rst_i,
    .cut_valid_i     ( req_cut_valid   ),
    .cut_id_i        ( req_cut.id      ),
    .hit_i           ( slot_hit        ),
    .mst_rsp_valid_i ( mst_rsp_valid_i ),
    .mst_rsp_resp_i  ( mst_rsp_resp_i  ),
    .launch_o        ( launch          ),
    .mst_rsp_ready_o ( mst_rsp_ready_o ),
    .rsp_valid_o     ( join_rsp_valid  ),
    .rsp_id_o        ( join_rsp_id     ),
    .rsp_resp_o      ( join_rsp_resp   ),
    .rsp_ready_i     ( join_rsp_ready  )
  );

  beat_spill_reg #(
    .T ( rsp_beat_t )
  ) i_rsp_cut (
    .clk_i,
    .rst_i,
    .valid_i ( join_rsp_valid                ),
    .ready_o ( join_rsp_ready                ),
    .data_i  ( {join_rsp_id, join_rsp_resp} ),
    .valid_o ( slv_rsp_valid_o               ),
    .ready_i ( slv_rsp_ready_i               ),
    .data_o  ( rsp_out                       )
  );

  assign slv_rsp_id_o   = rsp_out.id;
  assign slv_rsp_resp_o = rsp_out.resp;

endmodule

/* project.f */
mcast_pkg.sv
beat_spill_reg.sv
mcast_port_slot.sv
mcast_rsp_join.sv
mcast_write_demux.sv
tb_mcast_write_demux.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_mcast_write_demux
log=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module "$top" -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Any failure line in the log fails the run
if grep -q "Testbench failed" "$log"; then
  exit 1
fi
exit 0

/* tb_mcast_write_demux.sv */
`timescale 1ns/1ns

module tb_mcast_write_demux;

  import mcast_pkg::*;

  localparam int          NUM_TESTS  = 16;
  localparam int          NUM_FIELDS = 7;
  localparam logic [31:0] SEED       = 32'h5494a5ce;

  logic       clk_i;
  logic       rst_i;
  logic       slv_req_valid_i;
  logic       slv_req_ready_o;
  addr_t      slv_req_addr_i;
  addr_t      slv_req_mask_i;
  data_t      slv_req_data_i;
  id_t        slv_req_id_i;
  logic       slv_rsp_valid_o;
  logic       slv_rsp_ready_i;
  id_t        slv_rsp_id_o;
  resp_t      slv_rsp_resp_o;
  port_mask_t mst_req_valid_o;
  port_mask_t mst_req_ready_i;
  addr_t [NUM_PORTS-1:0] mst_req_addr_o;
  addr_t [NUM_PORTS-1:0] mst_req_mask_o;
  data_t [NUM_PORTS-1:0] mst_req_data_o;
  port_mask_t mst_req_is_mcast_o;
  port_mask_t mst_rsp_valid_i;
  port_mask_t mst_rsp_ready_o;
  resp_t [NUM_PORTS-1:0] mst_rsp_resp_i;

  mcast_write_demux i_mcast_write_demux (
    .clk_i, .rst_i,
    .slv_req_valid_i, .slv_req_ready_o, .slv_req_addr_i, .slv_req_mask_i,
    .slv_req_data_i, .slv_req_id_i,
    .slv_rsp_valid_o, .slv_rsp_ready_i, .slv_rsp_id_o, .slv_rsp_resp_o,
    .mst_req_valid_o, .mst_req_ready_i, .mst_req_addr_o, .mst_req_mask_o,
    .mst_req_data_o, .mst_req_is_mcast_o,
    .mst_rsp_valid_i, .mst_rsp_ready_o, .mst_rsp_resp_i
  );

  // Seven words per test, in file column order
  logic [31:0] pat_mem [NUM_TESTS*NUM_FIELDS];
  int          port_tests [NUM_PORTS][NUM_TESTS];
  int          port_cnt [NUM_PORTS];
  int          port_seen [NUM_PORTS];
  bit          test_bad [NUM_TESTS];
  int          err_count;
  int          bad_tests;
  bit          started;

  function automatic logic [31:0] pattern_field(input int t, input int f);
    return pat_mem[t*NUM_FIELDS+f];
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input int t, input string what,
                             input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: test %0d %s is %h, expected %h", $time, t, what, got, exp);
      err_count++;
      test_bad[t] = 1'b1;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Reset and request driver
  // ----------------------------------------

  initial begin
    logic [31:0] sel;
    rst_i           <= 1'b1;
    slv_req_valid_i <= 1'b0;
    slv_req_addr_i  <= '0;
    slv_req_mask_i  <= '0;
    slv_req_data_i  <= '0;
    slv_req_id_i    <= '0;
    $readmemh("mcast_patterns.txt", pat_mem);
    // Per port, the tests that must reach it, in order
    for (int t = 0; t < NUM_TESTS; t++) begin
      sel = pattern_field(t, 5);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (sel[p]) begin
          port_tests[p][port_cnt[p]] = t;
          port_cnt[p]++;
        end
      end
    end
    repeat (3) @(posedge clk_i);
    rst_i   <= 1'b0;
    started = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      slv_req_valid_i <= 1'b1;
      slv_req_addr_i  <= pattern_field(t, 0);
      slv_req_mask_i  <= pattern_field(t, 1);
      slv_req_data_i  <= pattern_field(t, 2);
      slv_req_id_i    <= id_t'(pattern_field(t, 3));
      do @(posedge clk_i); while (!slv_req_ready_o);
    end
    slv_req_valid_i <= 1'b0;
  end

  // ----------------------------------------
  // Target responders
  // ----------------------------------------

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_target
    logic  req_ready;
    logic  rsp_valid;
    resp_t rsp_resp;

    assign mst_req_ready_i[p] = req_ready;
    assign mst_rsp_valid_i[p] = rsp_valid;
    assign mst_rsp_resp_i[p]  = rsp_resp;

    initial begin : responder
      logic [31:0] rs;
      logic [31:0] inj;
      addr_t       exp_addr;
      addr_t       exp_mask;
      int          t;
      rs        = SEED ^ 32'(p + 1);
      req_ready <= 1'b0;
      rsp_valid <= 1'b0;
      rsp_resp  <= RESP_OKAY;
      wait (started);
      forever begin
        @(posedge clk_i);
        if (mst_req_valid_o[p]) begin
          rs = lcg_next(rs);
          repeat (int'(rs[18:16])) @(posedge clk_i);
          req_ready <= 1'b1;
          @(posedge clk_i);
          req_ready <= 1'b0;
          t   = -1;
          inj = '0;
          if (port_seen[p] < port_cnt[p]) begin
            t = port_tests[p][port_seen[p]];
          end else begin
            $display("port %0d got a request that no test selects, at %0t", p, $time);
            err_count++;
          end
          port_seen[p]++;
          if (t >= 0) begin
            // Copy moved into this port's region
            exp_addr = PORT_BASE[p] | (pattern_field(t, 0) & (PORT_SPAN - 1));
            exp_mask = pattern_field(t, 1) & (PORT_SPAN - 1);
            inj      = pattern_field(t, 4);
            check_value(t, $sformatf("port %0d addr", p), mst_req_addr_o[p], exp_addr);
            check_value(t, $sformatf("port %0d mask", p), mst_req_mask_o[p], exp_mask);
            check_value(t, $sformatf("port %0d data", p), mst_req_data_o[p],
                        pattern_field(t, 2));
            check_value(t, $sformatf("port %0d is_mcast", p), 32'(mst_req_is_mcast_o[p]),
                        32'(pattern_field(t, 1) != 0));
          end
          rs = lcg_next(rs);
          repeat (int'(rs[18:16])) @(posedge clk_i);
          rsp_valid <= 1'b1;
          rsp_resp  <= inj[p] ? RESP_SLVERR : RESP_OKAY;
          do @(posedge clk_i); while (!mst_rsp_ready_o[p]);
          rsp_valid <= 1'b0;
        end
      end
    end
  end

  // Responses in request order, under random stalls
  initial begin : rsp_monitor
    logic [31:0] rs;
    int          n;
    rs = SEED;
    n  = 0;
    slv_rsp_ready_i <= 1'b0;
    wait (started);
    while (n < NUM_TESTS) begin
      @(posedge clk_i);
      if (slv_rsp_valid_o && slv_rsp_ready_i) begin
        check_value(n, "response id", 32'(slv_rsp_id_o), pattern_field(n, 3));
        check_value(n, "response code", 32'(slv_rsp_resp_o), pattern_field(n, 6));
        if (test_bad[n]) begin
          bad_tests++;
          $display("test %0d id %h resp %0d: error", n, slv_rsp_id_o, slv_rsp_resp_o);
        end else begin
          $display("test %0d id %h resp %0d: ok", n, slv_rsp_id_o, slv_rsp_resp_o);
        end
        n++;
      end
      rs = lcg_next(rs);
      slv_rsp_ready_i <= (rs[17:16] != 2'b00);
    end
    slv_rsp_ready_i <= 1'b1;
    repeat (20) begin
      @(posedge clk_i);
      if (slv_rsp_valid_o) begin
        $display("an extra response with id %h came after the last test", slv_rsp_id_o);
        err_count++;
      end
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (port_seen[p] != port_cnt[p]) begin
        $display("port %0d got %0d requests instead of %0d", p, port_seen[p], port_cnt[p]);
        err_count++;
      end
    end
    $display("tests %0d, failed tests %0d, errors %0d", NUM_TESTS, bad_tests, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("timeout after %0d cycles, responses are missing", NUM_TESTS * 200);
    $display("Testbench failed");
    $finish;
  end

endmodule
